// File: hdl/z80_dp_pkg.sv
`default_nettype none

package z80_dp_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned byte_w = 8;
  localparam int unsigned word_w = 16;

  typedef logic [byte_w-1:0] byte_t;
  typedef logic [word_w-1:0] word_t;

  // bit positions inside F
  localparam int unsigned S_BIT  = 7;
  localparam int unsigned Z_BIT  = 6;
  localparam int unsigned H_BIT  = 4;
  localparam int unsigned PV_BIT = 2;
  localparam int unsigned N_BIT  = 1;
  localparam int unsigned C_BIT  = 0;

  // ------------------------------
  // encoded control fields
  // ------------------------------
  // single byte registers, high byte of a pair on the even code
  typedef enum logic [2:0] {
    REG_B   = 3'd0,
    REG_C   = 3'd1,
    REG_D   = 3'd2,
    REG_E   = 3'd3,
    REG_H   = 3'd4,
    REG_L   = 3'd5,
    REG_SPH = 3'd6,
    REG_SPL = 3'd7
  } reg8_e;

  typedef enum logic [1:0] {
    PAIR_BC = 2'd0,
    PAIR_DE = 2'd1,
    PAIR_HL = 2'd2,
    PAIR_SP = 2'd3
  } pair_e;

  // same opcode feeds both ALUs
  typedef enum logic [3:0] {
    ALU_NOP    = 4'd0,
    ALU_INCR   = 4'd1,
    ALU_DECR   = 4'd2,
    ALU_ADD    = 4'd3,
    ALU_PASS_B = 4'd4,
    ALU_ADD_SE = 4'd5
  } alu_op_e;

  // internal data bus sources, EXT means nobody drives
  typedef enum logic [2:0] {
    DSRC_EXT   = 3'd0,
    DSRC_REG   = 3'd1,
    DSRC_ACC   = 3'd2,
    DSRC_FLAGS = 3'd3,
    DSRC_TEMP  = 3'd4,
    DSRC_ALU   = 3'd5
  } data_src_e;

  typedef enum logic [1:0] {
    ASRC_NONE = 2'd0,
    ASRC_MAR  = 2'd1,
    ASRC_ALU  = 2'd2
  } addr_src_e;

  // one 16-bit register seen as a word or as two bytes
  typedef union packed {
    word_t w;
    struct packed {
      byte_t hi;
      byte_t lo;
    } b;
  } reg_word_u;

endpackage

`default_nettype wire

// File: hdl/dp_bus_if.sv
`default_nettype none

interface dp_bus_if;
  import z80_dp_pkg::*;

  // ------------------------------
  // shared buses
  // ------------------------------
  byte_t data_bus;
  word_t addr_bus;

  // register file read ports
  byte_t reg_byte;
  word_t reg_word;

  // accumulator and F register contents
  byte_t acc;
  byte_t flags;

  // ALU results and the flag words they would produce
  byte_t alu_byte;
  word_t alu_word;
  byte_t alu_flags_byte;
  byte_t alu_flags_word;

  // TEMP is the second operand of the word ALU
  byte_t temp;

  // ------------------------------
  // one view per module
  // ------------------------------
  modport regfile (
    input  data_bus,
    input  addr_bus,
    output reg_byte,
    output reg_word
  );

  modport alu (
    input  data_bus,
    input  reg_word,
    input  acc,
    input  flags,
    input  temp,
    output alu_byte,
    output alu_word,
    output alu_flags_byte,
    output alu_flags_word
  );

  modport acc_flags (
    input  data_bus,
    input  alu_flags_byte,
    input  alu_flags_word,
    output acc,
    output flags
  );

  modport bus (
    input  reg_byte,
    input  acc,
    input  flags,
    input  alu_byte,
    input  alu_word,
    output data_bus,
    output addr_bus,
    output temp
  );

endinterface

`default_nettype wire

// File: hdl/dp_regfile.sv
`default_nettype none

module dp_regfile (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire z80_dp_pkg::reg8_e reg_sel,
  input  wire z80_dp_pkg::pair_e pair_sel,
  input  wire logic              ld_byte,
  input  wire logic              ld_pair,
  input  wire logic              exx,
  input  wire logic              ex_de_hl,
  dp_bus_if.regfile              bus
);
  import z80_dp_pkg::*;

  // ------------------------------
  // register storage
  // ------------------------------
  // main set
  reg_word_u bc;
  reg_word_u de;
  reg_word_u hl;
  // stack pointer has no shadow
  reg_word_u sp;
  // alternate set, only reachable through exx
  reg_word_u bc_s;
  reg_word_u de_s;
  reg_word_u hl_s;

  // ------------------------------
  // update
  // ------------------------------
  // exchanges win over loads, exx wins over ex de,hl
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bc   <= '0;
      de   <= '0;
      hl   <= '0;
      sp   <= '0;
      bc_s <= '0;
      de_s <= '0;
      hl_s <= '0;
    end else if (exx) begin
      // all three pairs trade places with their shadows in one edge
      bc   <= bc_s;
      de   <= de_s;
      hl   <= hl_s;
      bc_s <= bc;
      de_s <= de;
      hl_s <= hl;
    end else if (ex_de_hl) begin
      de <= hl;
      hl <= de;
    end else if (ld_pair) begin
      // whole pair from the address bus
      case (pair_sel)
        PAIR_BC: bc.w <= bus.addr_bus;
        PAIR_DE: de.w <= bus.addr_bus;
        PAIR_HL: hl.w <= bus.addr_bus;
        PAIR_SP: sp.w <= bus.addr_bus;
        default: ;
      endcase
    end else if (ld_byte) begin
      // one byte from the data bus, the other half keeps its value
      case (reg_sel)
        REG_B:   bc.b.hi <= bus.data_bus;
        REG_C:   bc.b.lo <= bus.data_bus;
        REG_D:   de.b.hi <= bus.data_bus;
        REG_E:   de.b.lo <= bus.data_bus;
        REG_H:   hl.b.hi <= bus.data_bus;
        REG_L:   hl.b.lo <= bus.data_bus;
        REG_SPH: sp.b.hi <= bus.data_bus;
        REG_SPL: sp.b.lo <= bus.data_bus;
        default: ;
      endcase
    end
  end

  // ------------------------------
  // read muxes
  // ------------------------------
  // byte port feeds the data bus mux in bus_drive
  always_comb begin
    bus.reg_byte = '0;
    case (reg_sel)
      REG_B:   bus.reg_byte = bc.b.hi;
      REG_C:   bus.reg_byte = bc.b.lo;
      REG_D:   bus.reg_byte = de.b.hi;
      REG_E:   bus.reg_byte = de.b.lo;
      REG_H:   bus.reg_byte = hl.b.hi;
      REG_L:   bus.reg_byte = hl.b.lo;
      REG_SPH: bus.reg_byte = sp.b.hi;
      REG_SPL: bus.reg_byte = sp.b.lo;
      default: ;
    endcase
  end

  // word port is the first operand of the 16-bit ALU
  always_comb begin
    bus.reg_word = '0;
    case (pair_sel)
      PAIR_BC: bus.reg_word = bc.w;
      PAIR_DE: bus.reg_word = de.w;
      PAIR_HL: bus.reg_word = hl.w;
      PAIR_SP: bus.reg_word = sp.w;
      default: ;
    endcase
  end

  // ------------------------------
  // command checks
  // ------------------------------
  // only one bus may feed the file per cycle
  a_byte_pair_excl : assert property (@(posedge clk) disable iff (!arst_n)
    !(ld_byte && ld_pair));

  // an exchange would silently drop a load in the same cycle
  a_xchg_no_load : assert property (@(posedge clk) disable iff (!arst_n)
    (exx || ex_de_hl) |-> !(ld_byte || ld_pair));

endmodule

`default_nettype wire

// File: hdl/dp_alu.sv
`default_nettype none

module dp_alu (
  input  wire z80_dp_pkg::alu_op_e alu_op,
  dp_bus_if.alu                    bus
);
  import z80_dp_pkg::*;

  // ------------------------------
  // shared arithmetic
  // ------------------------------
  // both ALUs run at word width, the byte path truncates afterwards
  function automatic word_t alu_calc(alu_op_e op, word_t a, word_t b, word_t b_se);
    word_t r;
    case (op)
      ALU_INCR:   r = a + word_t'(1);
      ALU_DECR:   r = a - word_t'(1);
      ALU_ADD:    r = a + b;
      ALU_PASS_B: r = b;
      ALU_ADD_SE: r = a + b_se;
      // NOP and unused codes pass A through
      default:    r = a;
    endcase
    return r;
  endfunction

  // only DECR touches a flag, PV marks a nonzero result
  function automatic byte_t pv_calc(alu_op_e op, byte_t f, logic is_zero);
    byte_t r;
    r = f;
    if (op == ALU_DECR) begin
      r[PV_BIT] = !is_zero;
    end
    return r;
  endfunction

  // ------------------------------
  // operands
  // ------------------------------
  word_t temp_zx;
  word_t temp_se;
  byte_t byte_res;
  word_t word_res;

  assign temp_zx = word_t'(bus.temp);
  assign temp_se = {{(word_w-byte_w){bus.temp[byte_w-1]}}, bus.temp};

  // byte ALU works on A and the data bus, i.e. data_in when data_src is EXT
  // sign extension within 8 bits changes nothing, so ADD_SE acts like ADD here
  assign byte_res = byte_t'(alu_calc(alu_op, word_t'(bus.acc),
                                     word_t'(bus.data_bus), word_t'(bus.data_bus)));

  // word ALU works on the selected pair and TEMP
  assign word_res = alu_calc(alu_op, bus.reg_word, temp_zx, temp_se);

  // ------------------------------
  // results
  // ------------------------------
  assign bus.alu_byte       = byte_res;
  assign bus.alu_word       = word_res;
  assign bus.alu_flags_byte = pv_calc(alu_op, bus.flags, byte_res == '0);
  assign bus.alu_flags_word = pv_calc(alu_op, bus.flags, word_res == '0);

endmodule

`default_nettype wire

// File: hdl/acc_flags.sv
`default_nettype none

module acc_flags (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              ld_a,
  input  wire logic              ld_f_byte,
  input  wire logic              ld_f_word,
  input  wire logic              ex_af,
  input  wire z80_dp_pkg::byte_t flag_set,
  input  wire z80_dp_pkg::byte_t flag_clr,
  dp_bus_if.acc_flags            bus
);
  import z80_dp_pkg::*;

  // ------------------------------
  // A, F and their shadows
  // ------------------------------
  byte_t a_q;
  byte_t f_q;
  byte_t a_s;
  byte_t f_s;

  byte_t f_next;
  logic  f_upd;

  // pick the ALU flag word, then force bits on top
  always_comb begin
    f_next = f_q;
    if (ld_f_byte) begin
      f_next = bus.alu_flags_byte;
    end else if (ld_f_word) begin
      f_next = bus.alu_flags_word;
    end
    // clear first, set last
    f_next = (f_next & ~flag_clr) | flag_set;
  end

  // any load or mask bit writes F
  assign f_upd = ld_f_byte | ld_f_word | (|flag_set) | (|flag_clr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= '0;
      f_q <= '0;
      a_s <= '0;
      f_s <= '0;
    end else if (ex_af) begin
      // exchange blocks every load in the same cycle
      a_q <= a_s;
      a_s <= a_q;
      f_q <= f_s;
      f_s <= f_q;
    end else begin
      if (ld_a) begin
        a_q <= bus.data_bus;
      end
      if (f_upd) begin
        f_q <= f_next;
      end
    end
  end

  assign bus.acc   = a_q;
  assign bus.flags = f_q;

  // ------------------------------
  // command checks
  // ------------------------------
  a_mask_overlap : assert property (@(posedge clk) disable iff (!arst_n)
    (flag_set & flag_clr) == '0);

  a_one_flag_src : assert property (@(posedge clk) disable iff (!arst_n)
    !(ld_f_byte && ld_f_word));

endmodule

`default_nettype wire

// File: hdl/bus_drive.sv
`default_nettype none

module bus_drive (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire z80_dp_pkg::byte_t     data_in,
  input  wire z80_dp_pkg::data_src_e data_src,
  input  wire z80_dp_pkg::addr_src_e addr_src,
  input  wire logic                  ld_temp,
  input  wire logic                  ld_mar_hi,
  input  wire logic                  ld_mar_lo,
  output z80_dp_pkg::byte_t          data_out,
  output logic                       data_drive,
  output z80_dp_pkg::word_t          addr_out,
  output logic                       addr_drive,
  dp_bus_if.bus                      bus
);
  import z80_dp_pkg::*;

  byte_t     temp_q;
  reg_word_u mar;
  byte_t     data_sel;
  word_t     addr_sel;

  // ------------------------------
  // data bus mux
  // ------------------------------
  // external input owns the bus unless an internal source is selected
  always_comb begin
    data_sel   = data_in;
    data_drive = 1'b1;
    case (data_src)
      DSRC_REG:   data_sel = bus.reg_byte;
      DSRC_ACC:   data_sel = bus.acc;
      DSRC_FLAGS: data_sel = bus.flags;
      DSRC_TEMP:  data_sel = temp_q;
      DSRC_ALU:   data_sel = bus.alu_byte;
      default:    data_drive = 1'b0;
    endcase
  end

  assign bus.data_bus = data_sel;
  // pins stay quiet while the bus is only listening
  assign data_out     = data_drive ? data_sel : '0;

  // ------------------------------
  // address bus mux
  // ------------------------------
  always_comb begin
    addr_sel   = '0;
    addr_drive = 1'b0;
    case (addr_src)
      ASRC_MAR: begin
        addr_sel   = mar.w;
        addr_drive = 1'b1;
      end
      ASRC_ALU: begin
        addr_sel   = bus.alu_word;
        addr_drive = 1'b1;
      end
      default: ;
    endcase
  end

  assign bus.addr_bus = addr_sel;
  assign addr_out     = addr_sel;

  // ------------------------------
  // TEMP and MAR
  // ------------------------------
  // MAR is built a byte at a time from the data bus
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      temp_q <= '0;
      mar    <= '0;
    end else begin
      if (ld_temp) begin
        temp_q <= data_sel;
      end
      if (ld_mar_hi) begin
        mar.b.hi <= data_sel;
      end
      if (ld_mar_lo) begin
        mar.b.lo <= data_sel;
      end
    end
  end

  assign bus.temp = temp_q;

  a_addr_src_known : assert property (@(posedge clk) disable iff (!arst_n)
    addr_src inside {ASRC_NONE, ASRC_MAR, ASRC_ALU});

endmodule

`default_nettype wire

// File: hdl/z80_dp_top.sv
`default_nettype none

module z80_dp_top (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire z80_dp_pkg::byte_t     data_in,
  // register file commands
  input  wire z80_dp_pkg::reg8_e     reg_sel,
  input  wire z80_dp_pkg::pair_e     pair_sel,
  input  wire logic                  ld_byte,
  input  wire logic                  ld_pair,
  input  wire logic                  exx,
  input  wire logic                  ex_de_hl,
  // accumulator and flag commands
  input  wire logic                  ld_a,
  input  wire logic                  ld_f_byte,
  input  wire logic                  ld_f_word,
  input  wire logic                  ex_af,
  input  wire z80_dp_pkg::byte_t     flag_set,
  input  wire z80_dp_pkg::byte_t     flag_clr,
  input  wire z80_dp_pkg::alu_op_e   alu_op,
  // bus control
  input  wire z80_dp_pkg::data_src_e data_src,
  input  wire z80_dp_pkg::addr_src_e addr_src,
  input  wire logic                  ld_temp,
  input  wire logic                  ld_mar_hi,
  input  wire logic                  ld_mar_lo,
  output z80_dp_pkg::byte_t          data_out,
  output logic                       data_drive,
  output z80_dp_pkg::word_t          addr_out,
  output logic                       addr_drive,
  output z80_dp_pkg::byte_t          flags
);

  // internal buses and operand words
  dp_bus_if dp_bus ();

  dp_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .reg_sel  (reg_sel),
    .pair_sel (pair_sel),
    .ld_byte  (ld_byte),
    .ld_pair  (ld_pair),
    .exx      (exx),
    .ex_de_hl (ex_de_hl),
    .bus      (dp_bus.regfile)
  );

  dp_alu u_alu (
    .alu_op (alu_op),
    .bus    (dp_bus.alu)
  );

  acc_flags u_acc_flags (
    .clk       (clk),
    .arst_n    (arst_n),
    .ld_a      (ld_a),
    .ld_f_byte (ld_f_byte),
    .ld_f_word (ld_f_word),
    .ex_af     (ex_af),
    .flag_set  (flag_set),
    .flag_clr  (flag_clr),
    .bus       (dp_bus.acc_flags)
  );

  bus_drive u_bus_drive (
    .clk        (clk),
    .arst_n     (arst_n),
    .data_in    (data_in),
    .data_src   (data_src),
    .addr_src   (addr_src),
    .ld_temp    (ld_temp),
    .ld_mar_hi  (ld_mar_hi),
    .ld_mar_lo  (ld_mar_lo),
    .data_out   (data_out),
    .data_drive (data_drive),
    .addr_out   (addr_out),
    .addr_drive (addr_drive),
    .bus        (dp_bus.bus)
  );

  // control unit watches F directly
  assign flags = dp_bus.flags;

endmodule

`default_nettype wire

// File: testbench/tb_z80_dp.sv
`default_nettype none

module tb_z80_dp;
  import z80_dp_pkg::*;

  // ------------------------------
  // run length
  // ------------------------------
  // reset check, six tests, final idle
  localparam int unsigned cmd_count     = 1 + 16 + 20 + 47 + 50 + 34 + 16 + 1;
  localparam int unsigned clk_period    = 20;
  localparam int unsigned margin_cycles = 50;

  logic      clk;
  logic      arst_n;
  byte_t     data_in;
  reg8_e     reg_sel;
  pair_e     pair_sel;
  logic      ld_byte;
  logic      ld_pair;
  logic      exx;
  logic      ex_de_hl;
  logic      ld_a;
  logic      ld_f_byte;
  logic      ld_f_word;
  logic      ex_af;
  byte_t     flag_set;
  byte_t     flag_clr;
  alu_op_e   alu_op;
  data_src_e data_src;
  addr_src_e addr_src;
  logic      ld_temp;
  logic      ld_mar_hi;
  logic      ld_mar_lo;
  byte_t     data_out;
  logic      data_drive;
  word_t     addr_out;
  logic      addr_drive;
  byte_t     flags;

  z80_dp_top dut (.*);

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------
  // shadow model and expectations
  // ------------------------------
  // B C D E H L SPH SPL, then the B' .. L' shadows
  byte_t rf [8];
  byte_t rf_s [6];
  byte_t a_m;
  byte_t f_m;
  byte_t a_sm;
  byte_t f_sm;
  byte_t temp_m;
  word_t mar_m;

  byte_t exp_dout;
  logic  exp_ddrv;
  word_t exp_aout;
  logic  exp_adrv;
  byte_t exp_flags;
  logic  chk_en;
  string test_name;

  int unsigned n_cmds;
  int unsigned n_checks;
  int unsigned n_value_err;
  int unsigned n_unknown_err;
  logic [31:0] lfsr_q;

  // right-shifting Galois LFSR with taps 32 30 26 25 and one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // byte ALU result of A against the data bus
  function automatic byte_t alu8_ref(input alu_op_e op, input byte_t a, input byte_t b);
    case (op)
      ALU_INCR:            return a + 8'd1;
      ALU_DECR:            return a - 8'd1;
      ALU_ADD, ALU_ADD_SE: return a + b;
      ALU_PASS_B:          return b;
      default:             return a;
    endcase
  endfunction

  // word ALU result of a pair against TEMP
  function automatic word_t alu16_ref(input alu_op_e op, input word_t w, input byte_t t);
    case (op)
      ALU_INCR:   return w + 16'd1;
      ALU_DECR:   return w - 16'd1;
      ALU_ADD:    return w + {8'h00, t};
      ALU_PASS_B: return {8'h00, t};
      ALU_ADD_SE: return w + {{8{t[7]}}, t};
      default:    return w;
    endcase
  endfunction

  // PV after DECR marks a nonzero result
  function automatic byte_t decr_flags(input alu_op_e op, input byte_t f, input logic nz);
    byte_t r;
    r = f;
    if (op == ALU_DECR) begin
      r[PV_BIT] = nz;
    end
    return r;
  endfunction

  function automatic word_t pair_ref(input pair_e p);
    int i;
    i = 2 * int'(p);
    return {rf[i], rf[i+1]};
  endfunction

  // b operand unused by the ops issued with data_src ALU
  function automatic byte_t bus_ref();
    case (data_src)
      DSRC_REG:   return rf[reg_sel];
      DSRC_ACC:   return a_m;
      DSRC_FLAGS: return f_m;
      DSRC_TEMP:  return temp_m;
      DSRC_ALU:   return alu8_ref(alu_op, a_m, 8'h00);
      default:    return data_in;
    endcase
  endfunction

  function automatic word_t addr_ref();
    case (addr_src)
      ASRC_MAR: return mar_m;
      ASRC_ALU: return alu16_ref(alu_op, pair_ref(pair_sel), temp_m);
      default:  return 16'h0000;
    endcase
  endfunction

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic drive_idle();
    data_in   = '0;
    reg_sel   = REG_B;
    pair_sel  = PAIR_BC;
    ld_byte   = 1'b0;
    ld_pair   = 1'b0;
    exx       = 1'b0;
    ex_de_hl  = 1'b0;
    ld_a      = 1'b0;
    ld_f_byte = 1'b0;
    ld_f_word = 1'b0;
    ex_af     = 1'b0;
    flag_set  = '0;
    flag_clr  = '0;
    alu_op    = ALU_NOP;
    data_src  = DSRC_EXT;
    addr_src  = ASRC_NONE;
    ld_temp   = 1'b0;
    ld_mar_hi = 1'b0;
    ld_mar_lo = 1'b0;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    drive_idle();
  endtask

  // latch the expected outputs of this cycle, then step the model
  task automatic commit(input string name);
    byte_t db;
    word_t ab;
    byte_t r8;
    word_t r16;
    byte_t f_new;
    byte_t tmp;
    int    p;
    db        = bus_ref();
    ab        = addr_ref();
    r8        = alu8_ref(alu_op, a_m, db);
    r16       = alu16_ref(alu_op, pair_ref(pair_sel), temp_m);
    exp_ddrv  = (data_src != DSRC_EXT);
    exp_dout  = db;
    exp_adrv  = (addr_src == ASRC_MAR) || (addr_src == ASRC_ALU);
    exp_aout  = ab;
    exp_flags = f_m;
    test_name = name;
    chk_en    = 1'b1;
    n_cmds++;
    // register file exchanges come before loads
    if (exx) begin
      for (int i = 0; i < 6; i++) begin
        tmp     = rf[i];
        rf[i]   = rf_s[i];
        rf_s[i] = tmp;
      end
    end else if (ex_de_hl) begin
      tmp   = rf[2];
      rf[2] = rf[4];
      rf[4] = tmp;
      tmp   = rf[3];
      rf[3] = rf[5];
      rf[5] = tmp;
    end else if (ld_pair) begin
      p        = 2 * int'(pair_sel);
      rf[p]    = ab[15:8];
      rf[p+1]  = ab[7:0];
    end else if (ld_byte) begin
      rf[reg_sel] = db;
    end
    // A and F
    if (ex_af) begin
      tmp  = a_m;
      a_m  = a_sm;
      a_sm = tmp;
      tmp  = f_m;
      f_m  = f_sm;
      f_sm = tmp;
    end else begin
      if (ld_a) begin
        a_m = db;
      end
      if (ld_f_byte || ld_f_word || (flag_set != 0) || (flag_clr != 0)) begin
        f_new = f_m;
        if (ld_f_byte) begin
          f_new = decr_flags(alu_op, f_m, r8 != 8'h00);
        end else if (ld_f_word) begin
          f_new = decr_flags(alu_op, f_m, r16 != 16'h0000);
        end
        f_m = (f_new & ~flag_clr) | flag_set;
      end
    end
    if (ld_temp) begin
      temp_m = db;
    end
    if (ld_mar_hi) begin
      mar_m[15:8] = db;
    end
    if (ld_mar_lo) begin
      mar_m[7:0] = db;
    end
  endtask

  task automatic load_byte(input reg8_e r, input byte_t v);
    next_cycle();
    data_in = v;
    reg_sel = r;
    ld_byte = 1'b1;
    commit("byte load");
  endtask

  task automatic read_byte(input reg8_e r, input string name);
    next_cycle();
    reg_sel  = r;
    data_src = DSRC_REG;
    commit(name);
  endtask

  task automatic load_main();
    for (int i = 0; i < 6; i++) begin
      load_byte(reg8_e'(i), byte_t'(rand_bits(8)));
    end
  endtask

  task automatic read_main(input string name);
    for (int i = 0; i < 6; i++) begin
      read_byte(reg8_e'(i), name);
    end
  endtask

  task automatic swap_sets(input logic all_pairs, input string name);
    next_cycle();
    exx      = all_pairs;
    ex_de_hl = !all_pairs;
    commit(name);
  endtask

  task automatic alu_read(input alu_op_e op, input string name);
    next_cycle();
    alu_op   = op;
    data_src = DSRC_ALU;
    commit(name);
  endtask

  task automatic word_op(input alu_op_e op, input pair_e p, input logic ld_f, input string name);
    next_cycle();
    alu_op    = op;
    pair_sel  = p;
    addr_src  = ASRC_ALU;
    ld_f_word = ld_f;
    commit(name);
  endtask

  // A from data_in and F forced to a full byte in one cycle
  task automatic set_af(input byte_t a, input byte_t f);
    next_cycle();
    data_in  = a;
    ld_a     = 1'b1;
    flag_set = f;
    flag_clr = ~f;
    commit("af set");
  endtask

  task automatic read_af(input string name);
    next_cycle();
    data_src = DSRC_ACC;
    commit(name);
    next_cycle();
    data_src = DSRC_FLAGS;
    commit(name);
  endtask

  // ------------------------------
  // compare process
  // ------------------------------
  // outputs settle well before the middle of the low phase
  always begin
    @(negedge clk);
    #5;
    if (chk_en) begin
      n_checks++;
      if ($isunknown({data_drive, addr_drive, addr_out, flags})) begin
        $display("%s: DUT outputs carry unknown bits at time %0t", test_name, $time);
        n_unknown_err++;
      end
      if (data_drive !== exp_ddrv) begin
        $display("FAILED %s data_drive expected %0b actual %0b",
                 test_name, exp_ddrv, data_drive);
        n_value_err++;
      end
      if (exp_ddrv && (data_out !== exp_dout)) begin
        $display("FAILED %s data_out expected %02h actual %02h",
                 test_name, exp_dout, data_out);
        n_value_err++;
      end
      if (addr_drive !== exp_adrv) begin
        $display("FAILED %s addr_drive expected %0b actual %0b",
                 test_name, exp_adrv, addr_drive);
        n_value_err++;
      end
      if (addr_out !== exp_aout) begin
        $display("FAILED %s addr_out expected %04h actual %04h",
                 test_name, exp_aout, addr_out);
        n_value_err++;
      end
      if (flags !== exp_flags) begin
        $display("FAILED %s flags expected %02h actual %02h", test_name, exp_flags, flags);
        n_value_err++;
      end
    end
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    #((cmd_count + 5 + margin_cycles) * clk_period);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    word_t w;
    byte_t v;
    lfsr_q        = 32'h0f7e_f4ea;
    clk           = 1'b0;
    arst_n        = 1'b0;
    chk_en        = 1'b0;
    n_cmds        = 0;
    n_checks      = 0;
    n_value_err   = 0;
    n_unknown_err = 0;
    for (int i = 0; i < 8; i++) begin
      rf[i] = '0;
    end
    for (int i = 0; i < 6; i++) begin
      rf_s[i] = '0;
    end
    a_m    = '0;
    f_m    = '0;
    a_sm   = '0;
    f_sm   = '0;
    temp_m = '0;
    mar_m  = '0;
    drive_idle();
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    next_cycle();
    commit("reset state");

    // test 1 loads every byte register from data_in and reads it back over REG
    for (int i = 0; i < 8; i++) begin
      load_byte(reg8_e'(i), byte_t'(rand_bits(8)));
    end
    for (int i = 0; i < 8; i++) begin
      read_byte(reg8_e'(i), "byte readback");
    end

    // test 2 builds MAR from two byte loads and copies it into each pair
    for (int p = 0; p < 4; p++) begin
      w = word_t'(rand_bits(16));
      next_cycle();
      data_in   = w[15:8];
      ld_mar_hi = 1'b1;
      commit("mar hi load");
      next_cycle();
      data_in   = w[7:0];
      ld_mar_lo = 1'b1;
      commit("mar lo load");
      next_cycle();
      addr_src = ASRC_MAR;
      pair_sel = pair_e'(p);
      ld_pair  = 1'b1;
      commit("mar to pair");
      read_byte(reg8_e'(2 * p), "pair hi readback");
      read_byte(reg8_e'(2 * p + 1), "pair lo readback");
    end

    // test 3 covers the main/shadow exchange and the DE/HL swap
    load_main();
    swap_sets(1'b1, "exx");
    load_main();
    read_main("exx new main");
    swap_sets(1'b1, "exx back");
    read_main("exx restored");
    swap_sets(1'b0, "ex de hl");
    read_main("ex de hl readback");
    swap_sets(1'b1, "exx again");
    read_main("exx after swap");
    swap_sets(1'b1, "exx twice");
    read_main("exx twice readback");

    // test 4 byte ALU where operands 0 and 1 give the wrap and zero cases of DECR
    for (int i = 0; i < 10; i++) begin
      v = (i == 0) ? 8'h00 : (i == 1) ? 8'h01 : byte_t'(rand_bits(8));
      next_cycle();
      data_in = v;
      ld_a    = 1'b1;
      commit("acc load");
      alu_read(ALU_NOP, "alu8 nop");
      alu_read(ALU_INCR, "alu8 incr");
      alu_read(ALU_DECR, "alu8 decr");
      next_cycle();
      alu_op    = ALU_DECR;
      data_in   = byte_t'(rand_bits(8));
      ld_f_byte = 1'b1;
      commit("alu8 decr flag load");
    end

    // test 5 word ALU where the second round forces a negative TEMP
    // HL holds 0001 so its word DECR reaches zero and clears PV
    load_byte(REG_H, 8'h00);
    load_byte(REG_L, 8'h01);
    for (int r = 0; r < 2; r++) begin
      for (int p = 0; p < 4; p++) begin
        next_cycle();
        data_in = {r[0], 7'(rand_bits(7))};
        ld_temp = 1'b1;
        commit("temp load");
        word_op(ALU_ADD, pair_e'(p), 1'b0, "alu16 add");
        word_op(ALU_ADD_SE, pair_e'(p), 1'b0, "alu16 add sign ext");
        word_op(ALU_DECR, pair_e'(p), 1'b1, "alu16 decr flag load");
      end
    end

    // test 6 forces flags and then exercises the AF exchange
    for (int i = 0; i < 8; i++) begin
      next_cycle();
      flag_set = byte_t'(rand_bits(8));
      flag_clr = byte_t'(rand_bits(8)) & ~flag_set;
      data_src = DSRC_FLAGS;
      commit("flag force");
    end
    v = byte_t'(rand_bits(8));
    set_af(v, byte_t'(rand_bits(8)));
    next_cycle();
    ex_af = 1'b1;
    commit("ex af");
    v = byte_t'(rand_bits(8));
    set_af(v, byte_t'(rand_bits(8)));
    read_af("af new");
    next_cycle();
    ex_af = 1'b1;
    commit("ex af back");
    read_af("af shadow restored");

    next_cycle();
    commit("final idle");
    #10;
    $display("commands %0d, checks %0d, value errors %0d, unknown-value errors %0d",
             n_cmds, n_checks, n_value_err, n_unknown_err);
    if ((n_value_err == 0) && (n_unknown_err == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: z80_dp.f
hdl/z80_dp_pkg.sv
hdl/dp_bus_if.sv
hdl/dp_regfile.sv
hdl/dp_alu.sv
hdl/acc_flags.sv
hdl/bus_drive.sv
hdl/z80_dp_top.sv
testbench/tb_z80_dp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the z80_dp testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_z80_dp -f z80_dp.f \
  -o tb_z80_dp > sim.log 2>&1 \
  && ./obj_dir/tb_z80_dp >> sim.log 2>&1 \
  || { cat sim.log; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
